/* ssio_cfg.svh */
// Lane count must stay at ten to match the word struct and both frame counters wrap at full scale
`ifndef SSIO_CFG_SVH
`define SSIO_CFG_SVH

// Eight data lanes plus dv and er
`define SSIO_LANES 10

// Most 0x55 bytes accepted ahead of the SFD
// One more drops the frame
`define SSIO_PRE_MAX 7

// Good and dropped frame counters
`define SSIO_CNT_W 16

`endif

/* ssio_pkg.sv */
// Word layout assumes ten lanes ordered dv then er then data[7:0] from the top bit down
`include "ssio_cfg.svh"

package ssio_pkg;

    // Raw lane vector as seen at the pins
    typedef logic [`SSIO_LANES-1:0] ssio_lanes_t;

    // One captured GMII word
    // dv sits in lane 9 and er in lane 8
    typedef struct packed {
        logic       dv;
        logic       er;
        logic [7:0] data;
    } gmii_word_t;

    // One delivered payload byte
    typedef struct packed {
        // Payload data with preamble and SFD already stripped
        logic [7:0] data;
        // Set on the first byte after the SFD
        logic       first;
        // Set on the byte before dv falls
        logic       last;
        // Frame saw er somewhere, only reported with last
        logic       err;
    } rx_byte_t;

endpackage

/* ssio_sdr_in_diff.sv */
// Behavioral differential receiver only with no vendor buffers and the clock pair reads low when both legs are equal
`timescale 1ns/1ps
`include "ssio_cfg.svh"

module ssio_sdr_in_diff
    import ssio_pkg::*;
(
    // Forwarded clock pair
    input  logic                   input_clk_p,
    input  logic                   input_clk_n,

    // Data pairs, lane 9 is dv and lane 8 is er
    input  logic [`SSIO_LANES-1:0] input_d_p,
    input  logic [`SSIO_LANES-1:0] input_d_n,

    // Recovered clock passed on to the frame logic
    output logic                   output_clk,

    // Captured word, one stage after the pins
    output gmii_word_t             output_q
);

    // Single ended clock after the receiver
    logic        input_clk;

    // Lanes whose legs differ this cycle
    ssio_lanes_t lane_ok;

    // Capture register, one flop per lane
    ssio_lanes_t lane_q;

    // Complementary legs give the positive leg
    // A collapsed pair reads low
    assign input_clk = input_clk_p & ~input_clk_n;

    // Valid differential state per lane
    assign lane_ok = input_d_p ^ input_d_n;

    // Capture on the forwarded clock
    // Lanes with equal legs keep their last value
    always_ff @(posedge input_clk) begin
        lane_q <= (input_d_p & lane_ok) | (lane_q & ~lane_ok);
    end

    // Clock forwarded unchanged
    assign output_clk = input_clk;

    // Lanes repacked as a word
    assign output_q = gmii_word_t'(lane_q);

endmodule

/* gmii_rx_frame.sv */
// Bytes leave two cycles after the pins with no back-pressure and no CRC check so a frame needs dv low between frames
`timescale 1ns/1ps
`include "ssio_cfg.svh"

module gmii_rx_frame
    import ssio_pkg::*;
(
    input  logic                   output_clk,
    input  logic                   rst_n,

    // Word from the capture stage
    input  gmii_word_t             rx_word,

    // One strobe per payload byte
    output logic                   rx_valid,
    output rx_byte_t               rx_byte,

    // Frame statistics
    output logic [`SSIO_CNT_W-1:0] frame_count,
    output logic [`SSIO_CNT_W-1:0] drop_count
);

    localparam int       PRE_CNT_W     = $clog2(`SSIO_PRE_MAX + 1);
    localparam bit [7:0] PREAMBLE_BYTE = 8'h55;
    localparam bit [7:0] SFD_BYTE      = 8'hD5;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PRE,
        ST_PAYLOAD
    } state_t;

    state_t               state;
    state_t               state_nxt;
    logic [PRE_CNT_W-1:0] pre_cnt;
    logic [PRE_CNT_W-1:0] pre_cnt_nxt;

    // dv of the previous word for edge detect
    logic                 dv_prev;
    logic                 dv_rise;

    // One byte lookahead buffer
    logic                 pend_valid;
    logic [7:0]           pend_data;
    logic                 pend_first;

    // Sticky er over the whole frame
    logic                 err_seen;

    logic                 is_pre;
    logic                 is_sfd;
    logic                 pre_full;
    logic                 emit;
    logic                 emit_last;
    logic                 frame_done;
    logic                 frame_drop;

    // New frame only on a real rising dv
    // Keeps a dropped frame idle until dv goes low
    assign dv_rise  = rx_word.dv && !dv_prev;

    assign is_pre   = (rx_word.data == PREAMBLE_BYTE);
    assign is_sfd   = (rx_word.data == SFD_BYTE);
    assign pre_full = (pre_cnt == PRE_CNT_W'(`SSIO_PRE_MAX));

    // Next state and per cycle events
    always_comb begin
        state_nxt   = state;
        pre_cnt_nxt = pre_cnt;
        emit        = 1'b0;
        emit_last   = 1'b0;
        frame_done  = 1'b0;
        frame_drop  = 1'b0;

        case (state)
            ST_IDLE, ST_PRE: begin
                if (state == ST_PRE && !rx_word.dv) begin
                    // dv fell before the SFD
                    frame_drop  = 1'b1;
                    state_nxt   = ST_IDLE;
                    pre_cnt_nxt = '0;
                end else if (state == ST_PRE || dv_rise) begin
                    // First byte of a frame is checked like any preamble byte
                    if (is_sfd) begin
                        state_nxt   = ST_PAYLOAD;
                        pre_cnt_nxt = '0;
                    end else if (is_pre && !pre_full) begin
                        state_nxt   = ST_PRE;
                        pre_cnt_nxt = pre_cnt + 1'b1;
                    end else begin
                        // Bad byte or preamble too long
                        frame_drop  = 1'b1;
                        state_nxt   = ST_IDLE;
                        pre_cnt_nxt = '0;
                    end
                end
            end

            ST_PAYLOAD: begin
                // Held byte goes out once the next word is known
                emit      = pend_valid;
                emit_last = !rx_word.dv;
                if (!rx_word.dv) begin
                    state_nxt  = ST_IDLE;
                    frame_done = pend_valid;
                    // SFD straight into dv low carries no payload
                    frame_drop = !pend_valid;
                end
            end

            default: begin
                state_nxt   = ST_IDLE;
                pre_cnt_nxt = '0;
            end
        endcase
    end

    // Control state
    always_ff @(posedge output_clk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            pre_cnt     <= '0;
            dv_prev     <= 1'b0;
            pend_valid  <= 1'b0;
            err_seen    <= 1'b0;
            rx_valid    <= 1'b0;
            frame_count <= '0;
            drop_count  <= '0;
        end else begin
            state    <= state_nxt;
            pre_cnt  <= pre_cnt_nxt;
            dv_prev  <= rx_word.dv;
            rx_valid <= emit;

            // Lookahead holds a byte only while the frame runs
            pend_valid <= (state == ST_PAYLOAD) && rx_word.dv;

            // Restart on the rising word then accumulate
            if (state == ST_IDLE) begin
                err_seen <= dv_rise && rx_word.er;
            end else if (rx_word.dv) begin
                err_seen <= err_seen | rx_word.er;
            end

            if (frame_done) begin
                frame_count <= frame_count + 1'b1;
            end
            if (frame_drop) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

    // Payload path
    always_ff @(posedge output_clk) begin
        if (state == ST_PAYLOAD && rx_word.dv) begin
            pend_data  <= rx_word.data;
            // Empty buffer means this is the first byte after SFD
            pend_first <= !pend_valid;
        end
        if (emit) begin
            rx_byte.data  <= pend_data;
            rx_byte.first <= pend_first;
            rx_byte.last  <= emit_last;
            // err reported on the last byte only
            rx_byte.err   <= emit_last && err_seen;
        end
    end

endmodule

/* ssio_gmii_rx_top.sv */
// Single clock domain on the forwarded clock with rst_n sampled on output_clk and no DDR or CDC
`timescale 1ns/1ps
`include "ssio_cfg.svh"

module ssio_gmii_rx_top
    import ssio_pkg::*;
(
    // Differential pins
    input  logic                   input_clk_p,
    input  logic                   input_clk_n,
    input  logic [`SSIO_LANES-1:0] input_d_p,
    input  logic [`SSIO_LANES-1:0] input_d_n,

    // Synchronous reset on the recovered clock
    input  logic                   rst_n,

    output logic                   output_clk,

    // Payload byte stream
    output logic                   rx_valid,
    output rx_byte_t               rx_byte,

    // Statistics
    output logic [`SSIO_CNT_W-1:0] frame_count,
    output logic [`SSIO_CNT_W-1:0] drop_count
);

    // Captured word between receiver and frame logic
    gmii_word_t output_q;

    // Pin receiver and capture stage
    ssio_sdr_in_diff rx_in_inst (
        .input_clk_p (input_clk_p),
        .input_clk_n (input_clk_n),
        .input_d_p   (input_d_p),
        .input_d_n   (input_d_n),
        .output_clk  (output_clk),
        .output_q    (output_q)
    );

    // Preamble strip and byte delivery
    gmii_rx_frame rx_frame_inst (
        .output_clk  (output_clk),
        .rst_n       (rst_n),
        .rx_word     (output_q),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .frame_count (frame_count),
        .drop_count  (drop_count)
    );

endmodule

/* ssio_gmii_rx_checker.sv */
// Pin level model of the receive path that assumes valid idle words on the pins during reset
`timescale 1ns/1ps
`include "ssio_cfg.svh"

module ssio_gmii_rx_checker
    import ssio_pkg::*;
(
    input  logic                   clk,
    // Forwarded clock from the DUT
    input  logic                   output_clk,
    input  logic                   rst_n,
    input  logic [`SSIO_LANES-1:0] input_d_p,
    input  logic [`SSIO_LANES-1:0] input_d_n,
    input  logic                   rx_valid,
    input  rx_byte_t               rx_byte,
    input  logic [`SSIO_CNT_W-1:0] frame_count,
    input  logic [`SSIO_CNT_W-1:0] drop_count,
    // Raised once the line has gone idle
    input  logic                   finish_req,
    output logic                   finish_ack,
    output int                     value_errors,
    output int                     other_errors
);

    typedef enum {M_IDLE, M_PRE, M_PAY} mstate_t;

    ssio_lanes_t lanes = '0;
    gmii_word_t  w;
    mstate_t     st = M_IDLE;
    int          ln;
    int          npre = 0;
    int          cyc = 0;
    int          oclk_edges = 0;
    int          rst_cycles = 0;
    int          frames = 0;
    int          drops = 0;
    int          frame_no = 0;
    int          fn;
    logic        prev_dv = 1'b0;
    logic        err = 1'b0;
    logic        have_pend = 1'b0;
    logic        pend_first = 1'b0;
    logic [7:0]  pend_data = '0;
    rx_byte_t    eb;
    // Expected bytes with the cycle each one is due
    rx_byte_t    exp_q[$];
    int          due_q[$];
    int          frame_q[$];

    initial begin
        finish_ack   = 1'b0;
        value_errors = 0;
        other_errors = 0;
    end

    // Preamble or SFD byte at the head of a frame
    task automatic check_pre_byte();
        if (w.data == 8'hD5) begin
            st        = M_PAY;
            have_pend = 1'b0;
        end else if (w.data == 8'h55 && npre < `SSIO_PRE_MAX) begin
            npre = npre + 1;
            st   = M_PRE;
        end else begin
            drops = drops + 1;
            st    = M_IDLE;
        end
    endtask

    // Rising edges of the forwarded clock
    always @(posedge output_clk) begin
        oclk_edges = oclk_edges + 1;
    end

    // Model runs on the word captured at this edge
    always @(posedge clk) begin
        cyc = cyc + 1;
        // A lane with differing legs takes the positive leg, equal legs hold
        for (ln = 0; ln < `SSIO_LANES; ln++) begin
            if (input_d_p[ln] != input_d_n[ln]) begin
                lanes[ln] = input_d_p[ln];
            end
        end
        w = gmii_word_t'(lanes);
        if (!rst_n) begin
            rst_cycles = rst_cycles + 1;
            st         = M_IDLE;
            frames     = 0;
            drops      = 0;
            have_pend  = 1'b0;
        end else begin
            case (st)
                M_IDLE: begin
                    if (w.dv && !prev_dv) begin
                        frame_no = frame_no + 1;
                        npre     = 0;
                        err      = w.er;
                        check_pre_byte();
                    end
                end
                M_PRE: begin
                    if (!w.dv) begin
                        drops = drops + 1;
                        st    = M_IDLE;
                    end else begin
                        err = err | w.er;
                        check_pre_byte();
                    end
                end
                default: begin
                    // Held byte leaves one edge later, last known from this word
                    if (have_pend) begin
                        eb.data  = pend_data;
                        eb.first = pend_first;
                        eb.last  = !w.dv;
                        eb.err   = !w.dv && err;
                        exp_q.push_back(eb);
                        due_q.push_back(cyc + 1);
                        frame_q.push_back(frame_no);
                    end
                    if (w.dv) begin
                        err        = err | w.er;
                        pend_first = !have_pend;
                        pend_data  = w.data;
                        have_pend  = 1'b1;
                    end else begin
                        if (have_pend) begin
                            frames = frames + 1;
                        end else begin
                            drops = drops + 1;
                        end
                        have_pend = 1'b0;
                        st        = M_IDLE;
                    end
                end
            endcase
        end
        prev_dv = w.dv;
    end

    // Outputs are stable on the falling edge
    always @(negedge clk) begin
        if (!rst_n && rst_cycles >= 1 && {rx_valid, frame_count, drop_count} !== '0) begin
            $display("[FAIL] reset state: expected %h, actual %h", '0,
                     {rx_valid, frame_count, drop_count});
            value_errors = value_errors + 1;
        end
        if (oclk_edges != cyc) begin
            $display("[FAIL] output_clk rising edges: expected %0d, actual %0d",
                     cyc, oclk_edges);
            value_errors = value_errors + 1;
        end
        if (due_q.size() != 0 && due_q[0] == cyc) begin
            eb = exp_q.pop_front();
            void'(due_q.pop_front());
            fn = frame_q.pop_front();
            if (rx_valid !== 1'b1) begin
                $display("Byte of frame %0d did not arrive at cycle %0d", fn, cyc);
                other_errors = other_errors + 1;
            end else if (rx_byte !== eb) begin
                $display("[FAIL] frame %0d rx_byte: expected %h, actual %h", fn, eb, rx_byte);
                value_errors = value_errors + 1;
            end
        end else if (rx_valid === 1'b1) begin
            $display("Unexpected byte %h at cycle %0d", rx_byte, cyc);
            other_errors = other_errors + 1;
        end
        if (finish_req && !finish_ack) begin
            if (frame_count !== `SSIO_CNT_W'(frames)) begin
                $display("[FAIL] frame_count: expected %0d, actual %0d", frames, frame_count);
                value_errors = value_errors + 1;
            end
            if (drop_count !== `SSIO_CNT_W'(drops)) begin
                $display("[FAIL] drop_count: expected %0d, actual %0d", drops, drop_count);
                value_errors = value_errors + 1;
            end
            if (exp_q.size() != 0) begin
                $display("%0d expected bytes never arrived", exp_q.size());
                other_errors = other_errors + 1;
            end
            finish_ack = 1'b1;
        end
    end

endmodule

/* tb_ssio_gmii_rx.sv */
// Clock pair always stays complementary so only data lanes ever see equal legs
`timescale 1ns/1ps
`include "ssio_cfg.svh"

module tb_ssio_gmii_rx
    import ssio_pkg::*;
();

    localparam int N_FRAMES     = 200;
    localparam int PERIOD_NS    = 4;
    localparam int RESET_CYCLES = 10;
    // Payload, preamble, SFD and idle with slack
    localparam int WORST_FRAME  = 64 + 8 + 4 + 4;
    localparam int WATCHDOG_NS  = 2 * (N_FRAMES * WORST_FRAME + RESET_CYCLES) * PERIOD_NS;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic [`SSIO_LANES-1:0] d_p;
    logic [`SSIO_LANES-1:0] d_n;
    logic                   output_clk;
    logic                   rx_valid;
    rx_byte_t               rx_byte;
    logic [`SSIO_CNT_W-1:0] frame_count;
    logic [`SSIO_CNT_W-1:0] drop_count;
    logic                   finish_req;
    logic                   finish_ack;
    int                     value_errors;
    int                     other_errors;
    int                     f;

    always #(PERIOD_NS / 2) clk = ~clk;

    ssio_gmii_rx_top UUT (
        .input_clk_p (clk),
        .input_clk_n (~clk),
        .input_d_p   (d_p),
        .input_d_n   (d_n),
        .rst_n       (rst_n),
        .output_clk  (output_clk),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .frame_count (frame_count),
        .drop_count  (drop_count)
    );

    ssio_gmii_rx_checker chk (
        .clk          (clk),
        .output_clk   (output_clk),
        .rst_n        (rst_n),
        .input_d_p    (d_p),
        .input_d_n    (d_n),
        .rx_valid     (rx_valid),
        .rx_byte      (rx_byte),
        .frame_count  (frame_count),
        .drop_count   (drop_count),
        .finish_req   (finish_req),
        .finish_ack   (finish_ack),
        .value_errors (value_errors),
        .other_errors (other_errors)
    );

    // One word per cycle, masked lanes get equal legs
    task automatic drive_word(input logic dv, input logic er, input logic [7:0] data,
                              input logic [`SSIO_LANES-1:0] eq_mask);
        logic [`SSIO_LANES-1:0] w;
        @(negedge clk);
        w   = {dv, er, data};
        d_p = w;
        d_n = (~w & ~eq_mask) | (w & eq_mask);
    endtask

    // Kind 0 bad preamble, 1 long preamble, 2 er pulse, 3 equal legs, 4 no payload
    task automatic send_frame(input int kind);
        int                     len;
        int                     npre;
        int                     er_pos;
        int                     bad_pos;
        int                     i;
        logic [7:0]             data;
        logic [`SSIO_LANES-1:0] mask;
        len     = (kind == 4) ? 0 : $urandom_range(1, 64);
        npre    = (kind == 1) ? 8 : 7;
        er_pos  = $urandom_range(0, npre + len);
        bad_pos = $urandom_range(0, npre - 1);
        for (i = 0; i < npre + 1 + len; i++) begin
            if (i == npre) begin
                data = 8'hD5;
            end else if (i > npre) begin
                data = 8'($urandom);
            end else if (kind == 0 && i == bad_pos) begin
                // Never bit 7, so never an early SFD
                data = 8'h55 ^ (8'h01 << $urandom_range(0, 6));
            end else begin
                data = 8'h55;
            end
            mask = '0;
            if (kind == 3 && $urandom_range(0, 7) == 0) begin
                mask[$urandom_range(0, `SSIO_LANES - 1)] = 1'b1;
            end
            drive_word(1'b1, kind == 2 && i == er_pos, data, mask);
        end
        repeat ($urandom_range(1, 4)) drive_word(1'b0, 1'b0, 8'h00, '0);
    endtask

    initial begin
        void'($urandom(32'h8ac5410c));
        rst_n      = 1'b0;
        d_p        = '0;
        d_n        = '1;
        finish_req = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) drive_word(1'b0, 1'b0, 8'h00, '0);
        for (f = 0; f < N_FRAMES; f++) begin
            send_frame($urandom_range(0, 9));
        end
        // Let the last bytes drain
        repeat (8) drive_word(1'b0, 1'b0, 8'h00, '0);
        finish_req = 1'b1;
        wait (finish_ack === 1'b1);
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, run did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
ssio_pkg.sv
ssio_sdr_in_diff.sv
gmii_rx_frame.sv
ssio_gmii_rx_top.sv
ssio_gmii_rx_checker.sv
tb_ssio_gmii_rx.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the receive path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_ssio_gmii_rx -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
